//--- common/gf_pkg.sv
package gf_pkg;

   localparam int m      = 5;        // trits per element
   localparam int elem_w = 2 * m;    // two bits per trit

   // trit values 0, 1 and 2 are valid, 3 never appears in a stored element
   typedef logic [1:0] trit_t;

   typedef trit_t [m-1:0] gf_elem_t;    // trit 0 is the constant term

   // x^5 + 2x + 1, only the terms below x^5 are kept
   localparam gf_elem_t poly_low = {2'd0, 2'd0, 2'd0, 2'd2, 2'd1};

   localparam int wide_w = 3 * m - 2;   // trits of an unreduced cube, degree 3(m-1)

   typedef logic [$clog2(m)-1:0] step_t;
   localparam step_t mul_steps = step_t'(m - 1);   // mul steps left after the first

endpackage

//--- common/cop_pkg.sv
package cop_pkg;

   localparam int num_regs  = 8;
   localparam int rom_depth = 16;
   localparam int pc_w      = $clog2(rom_depth);
   localparam int adr_w     = 4;     // wishbone word address

   typedef enum logic [2:0] {
      op_halt = 3'd0,
      op_mov  = 3'd1,
      op_add  = 3'd2,
      op_sub  = 3'd3,
      op_cube = 3'd4,
      op_mul  = 3'd5
   } opcode_t;

   typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

   typedef struct packed {
      opcode_t  opcode;
      reg_idx_t dst;
      reg_idx_t src_a;
      reg_idx_t src_b;
   } instr_t;

   typedef struct packed {
      opcode_t          opcode;
      gf_pkg::gf_elem_t a;
      gf_pkg::gf_elem_t b;
   } alu_op_t;

   // routine 3 lands on an empty word, which reads back as halt
   localparam logic [3:0][pc_w-1:0] routine_entry = {4'd15, 4'd6, 4'd3, 4'd0};

   localparam logic [adr_w-1:0] wb_reg_ctrl = 4'd8;   // start on write, busy on read

endpackage

//--- coproc/cop_rom.sv
`timescale 1ns/1ps

module cop_rom (
   input  logic                     clk,
   input  logic [cop_pkg::pc_w-1:0] pc,
   output cop_pkg::instr_t          instr
);

   always_ff @(posedge clk) begin
      case (pc)
         // routine 0: r4 = r0*r1 + r2
         4'd0:    instr <= '{cop_pkg::op_mul,  3'd4, 3'd0, 3'd1};
         4'd1:    instr <= '{cop_pkg::op_add,  3'd4, 3'd4, 3'd2};
         4'd2:    instr <= '{cop_pkg::op_halt, 3'd0, 3'd0, 3'd0};
         // routine 1: r5 = r0^3 - r1
         4'd3:    instr <= '{cop_pkg::op_cube, 3'd5, 3'd0, 3'd0};
         4'd4:    instr <= '{cop_pkg::op_sub,  3'd5, 3'd5, 3'd1};
         4'd5:    instr <= '{cop_pkg::op_halt, 3'd0, 3'd0, 3'd0};
         // routine 2: r6 = (r0+r1)(r0-r1), r7 = r6^3
         4'd6:    instr <= '{cop_pkg::op_add,  3'd6, 3'd0, 3'd1};
         4'd7:    instr <= '{cop_pkg::op_sub,  3'd7, 3'd0, 3'd1};
         4'd8:    instr <= '{cop_pkg::op_mul,  3'd6, 3'd6, 3'd7};
         4'd9:    instr <= '{cop_pkg::op_cube, 3'd7, 3'd6, 3'd6};
         4'd10:   instr <= '{cop_pkg::op_halt, 3'd0, 3'd0, 3'd0};
         default: instr <= '{cop_pkg::op_halt, 3'd0, 3'd0, 3'd0};
      endcase
   end

endmodule

//--- coproc/cop_sequencer.sv
`timescale 1ns/1ps

module cop_sequencer (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start,
   input  logic [1:0]               routine,
   output logic                     busy,
   output logic [cop_pkg::pc_w-1:0] pc,
   input  cop_pkg::instr_t          instr,
   output cop_pkg::reg_idx_t        rd_a_idx,
   output cop_pkg::reg_idx_t        rd_b_idx,
   input  gf_pkg::gf_elem_t         rd_a,
   input  gf_pkg::gf_elem_t         rd_b,
   output cop_pkg::alu_op_t         alu_op,
   output logic                     alu_go,
   input  logic                     alu_done,
   input  gf_pkg::gf_elem_t         alu_result,
   output logic                     seq_we,
   output cop_pkg::reg_idx_t        seq_idx,
   output gf_pkg::gf_elem_t         seq_wdata
);

   typedef enum logic [1:0] {
      idle,
      fetch,
      issue,
      wait_alu
   } state_t;

   state_t state;

   // pc only moves after write-back, so instr stays valid through wait_alu
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
         busy  <= 1'b0;
         pc    <= '0;
      end else begin
         case (state)
            idle: begin
               if (start) begin
                  pc    <= cop_pkg::routine_entry[routine];
                  busy  <= 1'b1;
                  state <= fetch;
               end
            end
            fetch: state <= issue;                  // rom latches pc here
            issue: begin
               if (instr.opcode == cop_pkg::op_halt) begin
                  busy  <= 1'b0;
                  state <= idle;
               end else begin
                  state <= wait_alu;
               end
            end
            wait_alu: begin
               if (alu_done) begin
                  pc    <= pc + 1'b1;
                  state <= fetch;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   assign rd_a_idx = instr.src_a;
   assign rd_b_idx = instr.src_b;

   assign alu_go = (state == issue) && (instr.opcode != cop_pkg::op_halt);
   assign alu_op = '{opcode: instr.opcode, a: rd_a, b: rd_b};

   assign seq_we    = (state == wait_alu) && alu_done;
   assign seq_idx   = instr.dst;
   assign seq_wdata = alu_result;

endmodule

//--- coproc/gf_alu.sv
`timescale 1ns/1ps

module gf_alu (
   input  logic             clk,
   input  logic             rst_n,
   input  cop_pkg::alu_op_t alu_op,
   input  logic             alu_go,
   output logic             alu_done,
   output gf_pkg::gf_elem_t alu_result
);

   gf_pkg::gf_elem_t acc;      // single-cycle result or running product
   gf_pkg::gf_elem_t a_q;
   gf_pkg::gf_elem_t b_sh;     // multiplier digits, top trit next
   gf_pkg::step_t    steps;
   logic             mul_run;

   function automatic gf_pkg::trit_t trit_add(gf_pkg::trit_t x, gf_pkg::trit_t y);
      logic [2:0] s;
      s = x + y;
      return (s >= 3'd3) ? gf_pkg::trit_t'(s - 3'd3) : gf_pkg::trit_t'(s);
   endfunction

   function automatic gf_pkg::trit_t trit_mul(gf_pkg::trit_t x, gf_pkg::trit_t y);
      if (x == 2'd0 || y == 2'd0)
         return 2'd0;
      return (x == y) ? 2'd1 : 2'd2;   // 1*1 = 2*2 = 1
   endfunction

   function automatic gf_pkg::gf_elem_t elem_add(gf_pkg::gf_elem_t a, gf_pkg::gf_elem_t b);
      gf_pkg::gf_elem_t r;
      for (int i = 0; i < gf_pkg::m; i++)
         r[i] = trit_add(a[i], b[i]);
      return r;
   endfunction

   function automatic gf_pkg::gf_elem_t elem_scale(gf_pkg::gf_elem_t a, gf_pkg::trit_t t);
      gf_pkg::gf_elem_t r;
      for (int i = 0; i < gf_pkg::m; i++)
         r[i] = trit_mul(a[i], t);
      return r;
   endfunction

   function automatic gf_pkg::gf_elem_t elem_neg(gf_pkg::gf_elem_t a);
      return elem_scale(a, 2'd2);
   endfunction

   // a*x, with x^5 folded back as -(2x+1)
   function automatic gf_pkg::gf_elem_t mul_x(gf_pkg::gf_elem_t a);
      gf_pkg::gf_elem_t sh;
      sh = {a[gf_pkg::m-2:0], 2'd0};
      return elem_add(sh, elem_scale(elem_neg(gf_pkg::poly_low), a[gf_pkg::m-1]));
   endfunction

   // frobenius: a_i moves to x^(3i), then fold from the top degree down
   function automatic gf_pkg::gf_elem_t cube(gf_pkg::gf_elem_t a);
      gf_pkg::trit_t [gf_pkg::wide_w-1:0] w;
      gf_pkg::gf_elem_t negp;
      gf_pkg::trit_t c;
      w    = '0;
      negp = elem_neg(gf_pkg::poly_low);
      for (int i = 0; i < gf_pkg::m; i++)
         w[3*i] = a[i];
      for (int d = gf_pkg::wide_w - 1; d >= gf_pkg::m; d--) begin
         c = w[d];
         for (int j = 0; j < gf_pkg::m; j++)
            w[d-gf_pkg::m+j] = trit_add(w[d-gf_pkg::m+j], trit_mul(c, negp[j]));
      end
      return w[gf_pkg::m-1:0];
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_done <= 1'b0;
         mul_run  <= 1'b0;
         steps    <= '0;
      end else begin
         alu_done <= 1'b0;
         if (alu_go) begin
            if (alu_op.opcode == cop_pkg::op_mul) begin
               mul_run <= 1'b1;
               steps   <= gf_pkg::mul_steps;
            end else begin
               alu_done <= 1'b1;
            end
         end else if (mul_run) begin
            steps <= steps - 1'b1;
            if (steps == 1'b1) begin
               mul_run  <= 1'b0;
               alu_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alu_go) begin
         a_q  <= alu_op.a;
         b_sh <= {alu_op.b[gf_pkg::m-2:0], 2'd0};
         case (alu_op.opcode)
            cop_pkg::op_add:  acc <= elem_add(alu_op.a, alu_op.b);
            cop_pkg::op_sub:  acc <= elem_add(alu_op.a, elem_neg(alu_op.b));
            cop_pkg::op_cube: acc <= cube(alu_op.a);
            cop_pkg::op_mul:  acc <= elem_scale(alu_op.a, alu_op.b[gf_pkg::m-1]);  // acc was 0
            default:          acc <= alu_op.a;                                   // mov
         endcase
      end else if (mul_run) begin
         acc  <= elem_add(mul_x(acc), elem_scale(a_q, b_sh[gf_pkg::m-1]));
         b_sh <= {b_sh[gf_pkg::m-2:0], 2'd0};
      end
   end

   assign alu_result = acc;

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              host_we,
   input  cop_pkg::reg_idx_t host_idx,
   input  gf_pkg::gf_elem_t  host_wdata,
   output gf_pkg::gf_elem_t  host_rdata,
   input  cop_pkg::reg_idx_t rd_a_idx,
   input  cop_pkg::reg_idx_t rd_b_idx,
   output gf_pkg::gf_elem_t  rd_a,
   output gf_pkg::gf_elem_t  rd_b,
   input  logic              seq_we,
   input  cop_pkg::reg_idx_t seq_idx,
   input  gf_pkg::gf_elem_t  seq_wdata
);

   gf_pkg::gf_elem_t regs [cop_pkg::num_regs];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < cop_pkg::num_regs; i++)
            regs[i] <= '0;
      end else if (seq_we) begin
         regs[seq_idx] <= seq_wdata;        // sequencer wins
      end else if (host_we) begin
         regs[host_idx] <= host_wdata;
      end
   end

   assign rd_a       = regs[rd_a_idx];
   assign rd_b       = regs[rd_b_idx];
   assign host_rdata = regs[host_idx];

endmodule

//--- hw/wb_host_if.sv
`timescale 1ns/1ps

module wb_host_if (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      cyc,
   input  logic                      stb,
   input  logic                      we,
   input  logic [cop_pkg::adr_w-1:0] adr,
   input  logic [31:0]               dat_w,
   output logic [31:0]               dat_r,
   output logic                      ack,
   input  logic                      busy,
   output logic                      start,
   output logic [1:0]                routine,
   output logic                      host_we,
   output cop_pkg::reg_idx_t         host_idx,
   output gf_pkg::gf_elem_t          host_wdata,
   input  gf_pkg::gf_elem_t          host_rdata
);

   logic req;
   logic reg_sel;
   logic ctrl_sel;

   assign req      = cyc && stb && !ack;          // one cycle per classic transfer
   assign reg_sel  = adr < cop_pkg::wb_reg_ctrl;  // r0..r7 sit below the ctrl word
   assign ctrl_sel = adr == cop_pkg::wb_reg_ctrl;

   assign host_we    = req && we && reg_sel && !busy;
   assign host_idx   = adr[$bits(cop_pkg::reg_idx_t)-1:0];
   assign host_wdata = dat_w[gf_pkg::elem_w-1:0];

   assign start   = req && we && ctrl_sel && !busy;
   assign routine = dat_w[1:0];

   always_ff @(posedge clk) begin
      if (!rst_n)
         ack <= 1'b0;
      else
         ack <= req;
   end

   // read data lands together with ack
   always_ff @(posedge clk) begin
      if (req) begin
         if (reg_sel)
            dat_r <= 32'(host_rdata);
         else if (ctrl_sel)
            dat_r <= 32'(busy);
         else
            dat_r <= '0;
      end
   end

endmodule

//--- hw/gf_coproc_top.sv
`timescale 1ns/1ps

module gf_coproc_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      cyc,
   input  logic                      stb,
   input  logic                      we,
   input  logic [cop_pkg::adr_w-1:0] adr,
   input  logic [31:0]               dat_w,
   output logic [31:0]               dat_r,
   output logic                      ack
);

   logic                     start;
   logic [1:0]               routine;
   logic                     busy;
   logic                     host_we;
   cop_pkg::reg_idx_t        host_idx;
   gf_pkg::gf_elem_t         host_wdata;
   gf_pkg::gf_elem_t         host_rdata;
   logic [cop_pkg::pc_w-1:0] pc;
   cop_pkg::instr_t          instr;
   cop_pkg::reg_idx_t        rd_a_idx;
   cop_pkg::reg_idx_t        rd_b_idx;
   gf_pkg::gf_elem_t         rd_a;
   gf_pkg::gf_elem_t         rd_b;
   cop_pkg::alu_op_t         alu_op;
   logic                     alu_go;
   logic                     alu_done;
   gf_pkg::gf_elem_t         alu_result;
   logic                     seq_we;
   cop_pkg::reg_idx_t        seq_idx;
   gf_pkg::gf_elem_t         seq_wdata;

   wb_host_if i_wb_host_if (
      .clk        (clk),
      .rst_n      (rst_n),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .busy       (busy),
      .start      (start),
      .routine    (routine),
      .host_we    (host_we),
      .host_idx   (host_idx),
      .host_wdata (host_wdata),
      .host_rdata (host_rdata)
   );

   reg_file i_reg_file (
      .clk        (clk),
      .rst_n      (rst_n),
      .host_we    (host_we),
      .host_idx   (host_idx),
      .host_wdata (host_wdata),
      .host_rdata (host_rdata),
      .rd_a_idx   (rd_a_idx),
      .rd_b_idx   (rd_b_idx),
      .rd_a       (rd_a),
      .rd_b       (rd_b),
      .seq_we     (seq_we),
      .seq_idx    (seq_idx),
      .seq_wdata  (seq_wdata)
   );

   cop_sequencer i_cop_sequencer (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .routine    (routine),
      .busy       (busy),
      .pc         (pc),
      .instr      (instr),
      .rd_a_idx   (rd_a_idx),
      .rd_b_idx   (rd_b_idx),
      .rd_a       (rd_a),
      .rd_b       (rd_b),
      .alu_op     (alu_op),
      .alu_go     (alu_go),
      .alu_done   (alu_done),
      .alu_result (alu_result),
      .seq_we     (seq_we),
      .seq_idx    (seq_idx),
      .seq_wdata  (seq_wdata)
   );

   cop_rom i_cop_rom (
      .clk   (clk),
      .pc    (pc),
      .instr (instr)
   );

   gf_alu i_gf_alu (
      .clk        (clk),
      .rst_n      (rst_n),
      .alu_op     (alu_op),
      .alu_go     (alu_go),
      .alu_done   (alu_done),
      .alu_result (alu_result)
   );

endmodule

//--- sim/gf_coproc_props.sv
`timescale 1ns/1ps

module gf_coproc_props (
   input logic             clk,
   input logic             rst_n,
   input logic             cyc,
   input logic             stb,
   input logic             ack,
   input logic             busy,
   input logic             start,
   input logic             host_we,
   input gf_pkg::gf_elem_t host_wdata,
   input logic             seq_we,
   input gf_pkg::gf_elem_t seq_wdata
);

   function automatic logic has_bad_trit(gf_pkg::gf_elem_t e);
      logic bad;
      bad = 1'b0;
      for (int i = 0; i < gf_pkg::m; i++)
         bad = bad | (e[i] == 2'd3);
      return bad;
   endfunction

   ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> cyc && stb)
      else $error("ack raised outside a bus cycle");

   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ack |=> !ack)
      else $error("ack held longer than one cycle");

   host_wr_valid: assert property (@(posedge clk) disable iff (!rst_n)
      host_we |-> !has_bad_trit(host_wdata))
      else $error("host write carries trit 3");

   seq_wr_valid: assert property (@(posedge clk) disable iff (!rst_n)
      seq_we |-> !has_bad_trit(seq_wdata))
      else $error("sequencer write carries trit 3");

   busy_from_start: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(busy) |-> $past(start))
      else $error("busy rose without a start");

endmodule

bind gf_coproc_top gf_coproc_props i_gf_coproc_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .cyc        (cyc),
   .stb        (stb),
   .ack        (ack),
   .busy       (busy),
   .start      (start),
   .host_we    (host_we),
   .host_wdata (host_wdata),
   .seq_we     (seq_we),
   .seq_wdata  (seq_wdata)
);

//--- sim/tb_gf_coproc.sv
`timescale 1ns/1ps

module tb_gf_coproc;

   typedef struct packed {
      logic [1:0]       routine;
      gf_pkg::gf_elem_t r0;
      gf_pkg::gf_elem_t r1;
      gf_pkg::gf_elem_t r2;
      gf_pkg::gf_elem_t exp_a;   // r4, r5 or r6 depending on routine
      gf_pkg::gf_elem_t exp_b;   // r7, routine 2 only
   } vec_t;

   localparam int num_vecs   = 9;
   localparam int ack_limit  = 20;
   localparam int poll_limit = 200;
   localparam gf_pkg::gf_elem_t elem_one  = 10'b00_00_00_00_01;
   localparam gf_pkg::gf_elem_t elem_top2 = 10'b10_00_01_00_01;

   logic        clk;
   logic        rst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [3:0]  adr;
   logic [31:0] dat_w;
   logic [31:0] dat_r;
   logic        ack;

   vec_t        vecs [num_vecs];
   logic [31:0] lcg_state;
   int          errors;
   int          checks;

   gf_coproc_top i_gf_coproc_top (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic gf_pkg::gf_elem_t rand_elem();
      gf_pkg::gf_elem_t r;
      for (int i = 0; i < gf_pkg::m; i++)
         r[i] = gf_pkg::trit_t'((lcg_next() >> 16) % 3);   // valid trits only
      return r;
   endfunction

   // sign +1 adds, -1 subtracts, trit by trit mod 3
   function automatic gf_pkg::gf_elem_t model_add(gf_pkg::gf_elem_t a, gf_pkg::gf_elem_t b,
                                                  int sign);
      gf_pkg::gf_elem_t r;
      for (int i = 0; i < gf_pkg::m; i++)
         r[i] = gf_pkg::trit_t'((int'(a[i]) + sign * int'(b[i]) + 3) % 3);
      return r;
   endfunction

   // schoolbook product, then fold the high degrees with x^m = -poly_low
   function automatic gf_pkg::gf_elem_t model_mul(gf_pkg::gf_elem_t a, gf_pkg::gf_elem_t b);
      int c [2*gf_pkg::m-1];
      int t;
      gf_pkg::gf_elem_t r;
      for (int k = 0; k < 2 * gf_pkg::m - 1; k++)
         c[k] = 0;
      for (int i = 0; i < gf_pkg::m; i++)
         for (int j = 0; j < gf_pkg::m; j++)
            c[i+j] += int'(a[i]) * int'(b[j]);
      for (int d = 2 * gf_pkg::m - 2; d >= gf_pkg::m; d--) begin
         t    = c[d] % 3;
         c[d] = 0;
         for (int j = 0; j < gf_pkg::m; j++)
            c[d-gf_pkg::m+j] += t * (3 - int'(gf_pkg::poly_low[j]));
      end
      for (int i = 0; i < gf_pkg::m; i++)
         r[i] = gf_pkg::trit_t'(c[i] % 3);
      return r;
   endfunction

   function automatic gf_pkg::gf_elem_t model_cube(gf_pkg::gf_elem_t a);
      return model_mul(model_mul(a, a), a);
   endfunction

   function automatic vec_t expect_vec(vec_t v);
      vec_t r;
      r       = v;
      r.exp_b = '0;
      case (v.routine)
         2'd0:    r.exp_a = model_add(model_mul(v.r0, v.r1), v.r2, 1);
         2'd1:    r.exp_a = model_add(model_cube(v.r0), v.r1, -1);
         default: begin
            r.exp_a = model_mul(model_add(v.r0, v.r1, 1), model_add(v.r0, v.r1, -1));
            r.exp_b = model_cube(r.exp_a);
         end
      endcase
      return r;
   endfunction

   task automatic fill_table();
      for (int k = 0; k < num_vecs; k++) begin
         vecs[k].routine = 2'(k % 3);
         vecs[k].r0      = rand_elem();
         vecs[k].r1      = rand_elem();
         vecs[k].r2      = rand_elem();
      end
      vecs[0].r0 = '0;          // zero times anything
      vecs[3].r1 = elem_one;
      vecs[1].r0 = elem_top2;   // top trit 2 into the cube
      vecs[2].r1 = elem_top2;
      for (int k = 0; k < num_vecs; k++)
         vecs[k] = expect_vec(vecs[k]);
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("Test FAILED");
      $finish;
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   task automatic wb_cycle(input logic wr, input logic [3:0] a, input logic [31:0] d,
                           output logic [31:0] q);
      int n;
      n = 0;
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= wr;
      adr   <= a;
      dat_w <= d;
      @(negedge clk);
      while (!ack && n < ack_limit) begin
         @(negedge clk);
         n++;
      end
      if (!ack) begin
         stop_on_timeout("no ack on wishbone transfer");
      end else begin
         q = dat_r;
         @(posedge clk);
         cyc <= 1'b0;
         stb <= 1'b0;
         we  <= 1'b0;
      end
   endtask

   task automatic wb_write(input logic [3:0] a, input logic [31:0] d);
      logic [31:0] unused_q;
      wb_cycle(1'b1, a, d, unused_q);
   endtask

   task automatic wb_read(input logic [3:0] a, output logic [31:0] q);
      wb_cycle(1'b0, a, 32'd0, q);
   endtask

   task automatic read_and_check(input int idx, input gf_pkg::gf_elem_t exp, input string what);
      logic [31:0] q;
      wb_read(4'(idx), q);
      check_value(q, 32'(exp), what);
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      int n;
      n  = 0;
      st = 32'd1;
      while (st[0] && n < poll_limit) begin
         wb_read(cop_pkg::wb_reg_ctrl, st);
         n++;
      end
      if (st[0])
         stop_on_timeout("busy never cleared");
   endtask

   initial begin
      logic [31:0]      q;
      gf_pkg::gf_elem_t saved [cop_pkg::num_regs];
      gf_pkg::gf_elem_t prior_r5;
      vec_t             v;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      dat_w     = '0;
      rst_n     = 1'b0;
      errors    = 0;
      checks    = 0;
      lcg_state = 32'h469f;
      fill_table();
      apply_reset();

      for (int k = 0; k < cop_pkg::num_regs; k++) begin
         saved[k] = rand_elem();
         wb_write(4'(k), 32'(saved[k]));
      end
      for (int k = 0; k < cop_pkg::num_regs; k++)
         read_and_check(k, saved[k], "register round trip");
      apply_reset();
      for (int k = 0; k < cop_pkg::num_regs; k++)
         read_and_check(k, '0, "register after reset");

      for (int k = 0; k < num_vecs; k++) begin
         v = vecs[k];
         wb_write(4'd0, 32'(v.r0));
         wb_write(4'd1, 32'(v.r1));
         wb_write(4'd2, 32'(v.r2));
         wb_write(cop_pkg::wb_reg_ctrl, 32'(v.routine));
         wait_idle();
         read_and_check(4 + int'(v.routine), v.exp_a, "routine result");
         if (v.routine == 2'd2)
            read_and_check(7, v.exp_b, "r7 cube of r6");
      end

      // host traffic during a running routine must be dropped
      v        = vecs[0];
      prior_r5 = '0;
      for (int k = 0; k < num_vecs; k++)
         if (vecs[k].routine == 2'd1)
            prior_r5 = vecs[k].exp_a;   // last routine 1 result left in r5
      wb_write(4'd0, 32'(v.r0));
      wb_write(4'd1, 32'(v.r1));
      wb_write(4'd2, 32'(v.r2));
      wb_write(cop_pkg::wb_reg_ctrl, 32'd0);
      wb_write(4'd0, 32'(model_add(v.r0, elem_one, 1)));
      wb_write(cop_pkg::wb_reg_ctrl, 32'd1);
      wb_read(cop_pkg::wb_reg_ctrl, q);
      check_value(q, 32'd1, "busy while routine runs");
      wait_idle();
      read_and_check(4, v.exp_a, "r4 after ignored traffic");
      read_and_check(0, v.r0, "r0 kept while busy");
      read_and_check(5, prior_r5, "r5 untouched by ignored start");
      wb_read(cop_pkg::wb_reg_ctrl, q);
      check_value(q, 32'd0, "busy at end");

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- build.f
common/gf_pkg.sv
common/cop_pkg.sv
coproc/cop_rom.sv
coproc/cop_sequencer.sv
coproc/gf_alu.sv
hw/reg_file.sv
hw/wb_host_if.sv
hw/gf_coproc_top.sv
sim/gf_coproc_props.sv
sim/tb_gf_coproc.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gf_coproc -f build.f

out=$(./obj_dir/Vtb_gf_coproc 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
